// File: hw/cpu_bus_pkg.sv
package cpu_bus_pkg;

    // one data word, same width on the CPU and the bus side
    typedef logic [31:0] word_t;

    // Wishbone word address, byte offset bits dropped
    typedef logic [29:0] wb_addr_t;

    // byte enables for both bus words of an access
    // upper nibble is the first word, lower nibble the second one
    // a nonzero lower nibble means the access crosses a word boundary
    typedef logic [7:0] lane_pair_t;

    // access width as given by the CPU fullword and halfword inputs
    // encoding is {fullword, halfword}, both high is not a valid size
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_t;

    // number of address phases or acknowledges, 0 to 2
    typedef logic [1:0] phase_count_t;

    // word counts of an access
    localparam phase_count_t PHASES_ONE = 2'd1;
    localparam phase_count_t PHASES_TWO = 2'd2;

    // no byte touched, used for invalid sizes
    localparam lane_pair_t LANES_NONE = 8'b0000_0000;

endpackage

// File: hw/bus_lane_decode.sv
module bus_lane_decode (
    input  logic [1:0]                 addr_offset,
    input  cpu_bus_pkg::access_size_t  size,
    output cpu_bus_pkg::lane_pair_t    lanes,
    output cpu_bus_pkg::phase_count_t  words_needed
);

    import cpu_bus_pkg::*;

    // little-endian lane order, byte at offset 0 sits on lane 0
    always_comb begin
        lanes = LANES_NONE;
        case (size)
            // a byte never crosses a word
            size_byte: begin
                case (addr_offset)
                    2'd0: lanes = 8'b0001_0000;
                    2'd1: lanes = 8'b0010_0000;
                    2'd2: lanes = 8'b0100_0000;
                    2'd3: lanes = 8'b1000_0000;
                    default: lanes = LANES_NONE;
                endcase
            end
            size_half: begin
                case (addr_offset)
                    2'd0: lanes = 8'b0011_0000;
                    2'd1: lanes = 8'b0110_0000;
                    2'd2: lanes = 8'b1100_0000;
                    // top lane of word n, bottom lane of word n+1
                    2'd3: lanes = 8'b1000_0001;
                    default: lanes = LANES_NONE;
                endcase
            end
            size_word: begin
                case (addr_offset)
                    2'd0: lanes = 8'b1111_0000;
                    // unaligned words spill the high bytes into the next word
                    2'd1: lanes = 8'b1110_0001;
                    2'd2: lanes = 8'b1100_0011;
                    2'd3: lanes = 8'b1000_0111;
                    default: lanes = LANES_NONE;
                endcase
            end
            default: begin
                lanes = LANES_NONE;
            end
        endcase
    end

    // second bus word only when some lane of it is enabled
    assign words_needed = (lanes[3:0] != 4'b0000) ? PHASES_TWO : PHASES_ONE;

endmodule

// File: hw/wb_phase_sequencer.sv
module wb_phase_sequencer (
    input  logic                       I_clk,
    input  logic                       I_reset,
    input  logic                       strobe,
    input  logic                       write,
    input  cpu_bus_pkg::word_t         addr,
    input  cpu_bus_pkg::word_t         wdata,
    input  cpu_bus_pkg::lane_pair_t    lanes,
    input  cpu_bus_pkg::phase_count_t  words_needed,
    input  logic                       wb_ack,
    input  logic                       wb_stall,
    output logic                       wait_req,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output cpu_bus_pkg::wb_addr_t      wb_adr,
    output cpu_bus_pkg::word_t         wb_dat_w,
    output logic [3:0]                 wb_sel,
    output logic                       ack_take,
    output logic                       ack_phase
);

    import cpu_bus_pkg::*;

    logic         busy;
    logic         done;
    phase_count_t addr_count;
    phase_count_t addr_count_next;
    phase_count_t ack_count;
    phase_count_t ack_count_next;
    logic         start;
    logic         phase_accepted;
    logic         next_phase;
    logic [1:0]   addr_offset;
    logic [5:0]   overflow_shift;
    wb_addr_t     first_adr;
    word_t        dat_phase0;
    word_t        dat_phase1;

    assign addr_offset = addr[1:0];
    assign first_adr   = addr[31:2];

    // phase 0 moves the CPU bytes up to their lanes
    assign dat_phase0 = wdata << {addr_offset, 3'b000};
    // phase 1 takes the bytes that fell off the top of phase 0
    assign overflow_shift = {3'd4 - {1'b0, addr_offset}, 3'b000};
    assign dat_phase1     = wdata >> overflow_shift;

    assign addr_count_next = addr_count + 2'd1;
    assign ack_count_next  = ack_count + 2'd1;

    // done blocks a restart until the CPU has dropped strobe
    assign start          = strobe && !busy && !done;
    assign phase_accepted = wb_stb && !wb_stall;
    assign next_phase     = phase_accepted && (addr_count_next != words_needed);

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            wb_stb     <= 1'b0;
            wb_we      <= 1'b0;
            addr_count <= '0;
            ack_count  <= '0;
        end else if (!busy) begin
            if (!strobe) begin
                done <= 1'b0;
            end else if (start) begin
                busy   <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= write;
            end
        end else begin
            // stb and address hold while the slave stalls
            if (phase_accepted) begin
                addr_count <= addr_count_next;
                if (!next_phase) begin
                    wb_stb <= 1'b0;
                end
            end
            if (wb_ack) begin
                if (ack_count_next == words_needed) begin
                    // last acknowledge closes the cycle
                    busy       <= 1'b0;
                    done       <= 1'b1;
                    wb_we      <= 1'b0;
                    addr_count <= '0;
                    ack_count  <= '0;
                end else begin
                    ack_count <= ack_count_next;
                end
            end
        end
    end

    // address, data and select of the phase on the bus
    always_ff @(posedge I_clk) begin
        if (start) begin
            wb_adr   <= first_adr;
            wb_sel   <= lanes[7:4];
            wb_dat_w <= dat_phase0;
        end else if (next_phase) begin
            // wraps at the top of the address space
            wb_adr   <= first_adr + 30'd1;
            wb_sel   <= lanes[3:0];
            wb_dat_w <= dat_phase1;
        end
    end

    assign wb_cyc   = busy;
    assign wait_req = busy;

    // acknowledges come back in order, so the count names the phase
    assign ack_take  = busy && wb_ack;
    assign ack_phase = ack_count[0];

endmodule

// File: hw/read_data_merge.sv
module read_data_merge (
    input  logic                I_clk,
    input  logic                I_reset,
    input  logic                ack_take,
    input  logic                ack_phase,
    input  logic                write,
    input  logic [1:0]          addr_offset,
    input  cpu_bus_pkg::word_t  wb_dat_r,
    output cpu_bus_pkg::word_t  rdata
);

    // result byte j comes from access byte j, which sits at
    // lane (j + offset) of the first word, or of the second word
    // once that sum reaches 4
    // bit 2 of the sum selects the phase, bits 1:0 the lane
    for (genvar j = 0; j < 4; j++) begin : g_byte
        logic [2:0] lane_sum;
        logic       load;
        logic [7:0] lane_byte;

        assign lane_sum  = 3'(j) + {1'b0, addr_offset};
        assign lane_byte = wb_dat_r[8*lane_sum[1:0] +: 8];

        // writes also get acknowledged, only reads fill the result
        assign load = ack_take && !write && (lane_sum[2] == ack_phase);

        // bytes above the access size keep older contents
        always_ff @(posedge I_clk) begin
            if (I_reset) begin
                rdata[8*j +: 8] <= 8'h00;
            end else if (load) begin
                rdata[8*j +: 8] <= lane_byte;
            end
        end
    end

endmodule

// File: hw/wb_word_ram.sv
module wb_word_ram #(
    parameter int RAM_WORDS_LOG2 = 10,
    parameter int ACK_LATENCY    = 2
) (
    input  logic                   I_clk,
    input  logic                   I_reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  cpu_bus_pkg::wb_addr_t  wb_adr,
    input  cpu_bus_pkg::word_t     wb_dat_w,
    input  logic [3:0]             wb_sel,
    output logic                   wb_ack,
    output logic                   wb_stall,
    output cpu_bus_pkg::word_t     wb_dat_r
);

    import cpu_bus_pkg::*;

    localparam int DEPTH   = 2 ** RAM_WORDS_LOG2;
    localparam int DELAY_W = $clog2(ACK_LATENCY + 1);

    word_t                     mem [DEPTH];
    logic [RAM_WORDS_LOG2-1:0] index;
    logic [DELAY_W-1:0]        delay;
    logic                      accept;

    // upper address bits are ignored, the memory repeats
    assign index = wb_adr[RAM_WORDS_LOG2-1:0];

    // one phase at a time, stall keeps the master off while busy
    assign accept = wb_cyc && wb_stb && !wb_stall;

    // ack sits in the last stalled cycle, ACK_LATENCY cycles after accept
    assign wb_ack = wb_stall && (delay == '0);

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            wb_stall <= 1'b0;
            delay    <= '0;
        end else if (accept) begin
            wb_stall <= 1'b1;
            delay    <= DELAY_W'(ACK_LATENCY - 1);
        end else if (wb_ack) begin
            wb_stall <= 1'b0;
        end else if (wb_stall) begin
            delay <= delay - 1'b1;
        end
    end

    // storage and read word, both taken at accept time
    always_ff @(posedge I_clk) begin
        if (accept) begin
            if (wb_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_sel[b]) begin
                        mem[index][8*b +: 8] <= wb_dat_w[8*b +: 8];
                    end
                end
            end else begin
                wb_dat_r <= mem[index];
            end
        end
    end

endmodule

// File: hw/cpu_bus_top.sv
module cpu_bus_top #(
    parameter int RAM_WORDS_LOG2 = 10,
    parameter int ACK_LATENCY    = 2
) (
    input  logic                I_clk,
    input  logic                I_reset,
    input  logic                strobe,
    input  logic                write,
    input  logic                halfword,
    input  logic                fullword,
    input  cpu_bus_pkg::word_t  addr,
    input  cpu_bus_pkg::word_t  wdata,
    output cpu_bus_pkg::word_t  rdata,
    output logic                wait_req
);

    import cpu_bus_pkg::*;

    access_size_t size;
    logic [1:0]   addr_offset;
    lane_pair_t   lanes;
    phase_count_t words_needed;
    logic         ack_take;
    logic         ack_phase;

    // Wishbone between bridge and memory
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    wb_addr_t     wb_adr;
    word_t        wb_dat_w;
    logic [3:0]   wb_sel;
    logic         wb_ack;
    logic         wb_stall;
    word_t        wb_dat_r;

    // both size bits high lands on the undefined code, no lanes
    assign size        = access_size_t'({fullword, halfword});
    assign addr_offset = addr[1:0];

    bus_lane_decode i_lane_decode (
        .addr_offset  (addr_offset),
        .size         (size),
        .lanes        (lanes),
        .words_needed (words_needed)
    );

    wb_phase_sequencer i_phase_sequencer (
        .I_clk        (I_clk),
        .I_reset      (I_reset),
        .strobe       (strobe),
        .write        (write),
        .addr         (addr),
        .wdata        (wdata),
        .lanes        (lanes),
        .words_needed (words_needed),
        .wb_ack       (wb_ack),
        .wb_stall     (wb_stall),
        .wait_req     (wait_req),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .ack_take     (ack_take),
        .ack_phase    (ack_phase)
    );

    read_data_merge i_read_merge (
        .I_clk        (I_clk),
        .I_reset      (I_reset),
        .ack_take     (ack_take),
        .ack_phase    (ack_phase),
        .write        (write),
        .addr_offset  (addr_offset),
        .wb_dat_r     (wb_dat_r),
        .rdata        (rdata)
    );

    wb_word_ram #(
        .RAM_WORDS_LOG2 (RAM_WORDS_LOG2),
        .ACK_LATENCY    (ACK_LATENCY)
    ) i_word_ram (
        .I_clk    (I_clk),
        .I_reset  (I_reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_ack   (wb_ack),
        .wb_stall (wb_stall),
        .wb_dat_r (wb_dat_r)
    );

endmodule

// File: sim/tb_cpu_bus_asserts.sv
module tb_cpu_bus_asserts (
    input logic       I_clk,
    input logic       I_reset,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic [3:0] wb_sel,
    input logic       wb_ack,
    input logic       wait_req
);

    // a strobe outside a cycle is not a bus phase
    stb_inside_cyc: assert property (
        @(posedge I_clk) disable iff (I_reset) wb_stb |-> wb_cyc
    ) else $error("wb_stb high while wb_cyc is low");

    // every phase touches at least one byte lane
    sel_nonzero: assert property (
        @(posedge I_clk) disable iff (I_reset) wb_stb |-> (wb_sel != 4'b0000)
    ) else $error("wb_sel is zero during an address phase");

    // the CPU is released only by the final acknowledge
    wait_falls_after_ack: assert property (
        @(posedge I_clk) disable iff (I_reset) $fell(wait_req) |-> $past(wb_ack)
    ) else $error("wait_req fell without an acknowledge in the cycle before");

    // slave answers only inside a cycle
    ack_inside_cyc: assert property (
        @(posedge I_clk) disable iff (I_reset) wb_ack |-> wb_cyc
    ) else $error("wb_ack high while wb_cyc is low");

endmodule

bind wb_phase_sequencer tb_cpu_bus_asserts i_bus_asserts (
    .I_clk    (I_clk),
    .I_reset  (I_reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_sel   (wb_sel),
    .wb_ack   (wb_ack),
    .wait_req (wait_req)
);

// File: sim/tb_cpu_bus.sv
module tb_cpu_bus;

    import cpu_bus_pkg::*;

    localparam int RAM_WORDS_LOG2 = 10;
    localparam int ACK_LATENCY    = 2;
    localparam int RAM_WORDS      = 2 ** RAM_WORDS_LOG2;
    localparam int MEM_BYTES      = 4 * RAM_WORDS;
    localparam int WAIT_LIMIT     = 64;

    logic  I_clk;
    logic  I_reset;
    logic  strobe;
    logic  write;
    logic  halfword;
    logic  fullword;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  wait_req;

    // byte-wide reference copy of the memory
    logic [7:0] model_mem [MEM_BYTES];
    int         value_errors;
    int         timeout_errors;

    cpu_bus_top #(
        .RAM_WORDS_LOG2 (RAM_WORDS_LOG2),
        .ACK_LATENCY    (ACK_LATENCY)
    ) i_dut (
        .I_clk    (I_clk),
        .I_reset  (I_reset),
        .strobe   (strobe),
        .write    (write),
        .halfword (halfword),
        .fullword (fullword),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .wait_req (wait_req)
    );

    initial begin
        I_clk = 1'b0;
        forever #4 I_clk = ~I_clk;
    end

    // memory repeats every MEM_BYTES, so byte addresses wrap the same way
    function automatic int byte_index(input word_t a, input int j);
        return int'((a + word_t'(j)) & word_t'(MEM_BYTES - 1));
    endfunction

    // odd multiplier keeps every word address distinct
    function automatic word_t fill_pattern(input int index);
        return (word_t'(index) * 32'h9e37_79b1) ^ 32'h6a09_e667;
    endfunction

    task automatic check_word(input word_t got, input word_t expected, input word_t mask);
        if ((got & mask) !== (expected & mask)) begin
            $display("Fail rdata: got %h, expected %h, byte mask %h",
                     got & mask, expected & mask, mask);
            value_errors++;
        end
    endtask

    // one CPU access, returns after wait has risen and fallen again
    task automatic run_access(input logic wr, input int nbytes, input word_t a, input word_t d);
        int cycles;
        if (timeout_errors != 0) begin
            return;
        end
        @(posedge I_clk);
        strobe   <= 1'b1;
        write    <= wr;
        halfword <= (nbytes == 2);
        fullword <= (nbytes == 4);
        addr     <= a;
        wdata    <= d;
        cycles = 0;
        do begin
            @(negedge I_clk);
            cycles++;
        end while (!wait_req && cycles < WAIT_LIMIT);
        if (!wait_req) begin
            $display("timeout: wait_req never rose for the access at address %h", a);
            timeout_errors++;
        end else begin
            cycles = 0;
            do begin
                @(negedge I_clk);
                cycles++;
            end while (wait_req && cycles < WAIT_LIMIT);
            if (wait_req) begin
                $display("timeout: wait_req stayed high for the access at address %h", a);
                timeout_errors++;
            end
        end
        // strobe low for one cycle before the next access
        @(posedge I_clk);
        strobe <= 1'b0;
    endtask

    task automatic cpu_write(input word_t a, input int nbytes, input word_t d);
        run_access(1'b1, nbytes, a, d);
        for (int j = 0; j < nbytes; j++) begin
            model_mem[byte_index(a, j)] = d[8*j +: 8];
        end
    endtask

    task automatic cpu_read(input word_t a, input int nbytes);
        word_t expected;
        word_t mask;
        expected = '0;
        mask     = '0;
        for (int j = 0; j < nbytes; j++) begin
            expected[8*j +: 8] = model_mem[byte_index(a, j)];
            mask[8*j +: 8]     = 8'hff;
        end
        // write data is junk on a read and must not matter
        run_access(1'b0, nbytes, a, $urandom);
        if (timeout_errors == 0) begin
            check_word(rdata, expected, mask);
        end
    endtask

    // every word gets a known value before the tests read anything
    task automatic fill_memory();
        for (int i = 0; i < RAM_WORDS; i++) begin
            cpu_write(word_t'(i) << 2, 4, fill_pattern(i));
        end
    endtask

    task automatic check_aligned_words();
        word_t a;
        for (int n = 0; n < 16; n++) begin
            a = $urandom & 32'hffff_fffc;
            cpu_write(a, 4, $urandom);
            cpu_read(a, 4);
        end
    endtask

    task automatic merge_sub_word_stores();
        word_t base;
        for (int n = 0; n < 4; n++) begin
            base = $urandom & 32'hffff_fffc;
            cpu_write(base, 4, $urandom);
            for (int off = 0; off < 4; off++) begin
                cpu_write(base + word_t'(off), 1, $urandom);
                cpu_read(base, 4);
                cpu_read(base + word_t'(off), 1);
            end
            for (int off = 0; off < 4; off += 2) begin
                cpu_write(base + word_t'(off), 2, $urandom);
                cpu_read(base, 4);
                cpu_read(base + word_t'(off), 2);
            end
        end
    endtask

    // first pass sits on the top word so the second word wraps to zero
    task automatic cross_half_boundary();
        word_t base;
        for (int n = 0; n < 4; n++) begin
            base = (n == 0) ? 32'hffff_fffc : ($urandom & 32'hffff_fffc);
            cpu_write(base, 4, $urandom);
            cpu_write(base + 4, 4, $urandom);
            cpu_write(base + 3, 2, $urandom);
            cpu_read(base + 3, 2);
            cpu_read(base, 4);
            cpu_read(base + 4, 4);
        end
    endtask

    task automatic split_unaligned_words();
        word_t base;
        for (int off = 1; off < 4; off++) begin
            base = $urandom & 32'hffff_fffc;
            cpu_write(base + word_t'(off), 4, $urandom);
            cpu_read(base + word_t'(off), 4);
            cpu_read(base, 4);
            cpu_read(base + 4, 4);
        end
    endtask

    // small window so that reads often hit recent writes
    task automatic random_traffic();
        word_t window;
        word_t a;
        int    nbytes;
        window = $urandom;
        for (int n = 0; n < 200; n++) begin
            a      = window + ($urandom % 64);
            nbytes = 1 << ($urandom % 3);
            if ($urandom % 2) begin
                cpu_write(a, nbytes, $urandom);
            end else begin
                cpu_read(a, nbytes);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h3fa9a3b3));
        value_errors   = 0;
        timeout_errors = 0;
        I_reset  = 1'b1;
        strobe   = 1'b0;
        write    = 1'b0;
        halfword = 1'b0;
        fullword = 1'b0;
        addr     = '0;
        wdata    = '0;
        repeat (4) @(posedge I_clk);
        I_reset <= 1'b0;

        fill_memory();
        check_aligned_words();
        merge_sub_word_stores();
        cross_half_boundary();
        split_unaligned_words();
        random_traffic();

        $display("errors: %0d data mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: files.f
hw/cpu_bus_pkg.sv
hw/bus_lane_decode.sv
hw/wb_phase_sequencer.sv
hw/read_data_merge.sv
hw/wb_word_ram.sv
hw/cpu_bus_top.sv
sim/tb_cpu_bus_asserts.sv
sim/tb_cpu_bus.sv

// File: Makefile
TOP := tb_cpu_bus
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f hw/*.sv sim/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir $(LOG)
